//--- debug_pkg.sv
package debug_pkg;

    ////////////////////////////////////////
    // Clocking and UART framing.
    ////////////////////////////////////////

    localparam int CLOCK_FREQ_HZ    = 10_000_000;        // 100 ns system clock.
    localparam int BAUD_RATE        = 115200;
    localparam int OVERSAMPLE       = 16;                // Ticks per UART bit.
    localparam int TICK_DIVISOR     = CLOCK_FREQ_HZ / (OVERSAMPLE * BAUD_RATE);
    localparam int TICK_CNT_WIDTH   = $clog2(TICK_DIVISOR);
    localparam int SAMPLE_CNT_WIDTH = $clog2(OVERSAMPLE); // Tick position in a bit.
    localparam int STOP_BITS        = 2;
    localparam int STOP_CNT_WIDTH   = $clog2(STOP_BITS + 1);
    localparam int BYTE_WIDTH       = 8;
    localparam int BIT_CNT_WIDTH    = $clog2(BYTE_WIDTH);

    ////////////////////////////////////////
    // Program memory.
    ////////////////////////////////////////

    localparam int WORD_WIDTH     = 32;                   // Instruction width.
    localparam int ADDR_WIDTH     = 11;
    localparam int MEM_DEPTH      = 2048;                 // Must be 2**ADDR_WIDTH.
    localparam int BYTES_PER_WORD = WORD_WIDTH / BYTE_WIDTH;
    localparam int OPCODE_WIDTH   = 6;                    // Top bits of a word.
    localparam logic [OPCODE_WIDTH-1:0] HALT_OPCODE = '0;

    typedef logic [BYTE_WIDTH-1:0] byte_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Host command opcodes, one byte each.
    typedef enum logic [BYTE_WIDTH-1:0] {
        CMD_LOAD  = 8'h01,
        CMD_READ  = 8'h02,
        CMD_CLEAR = 8'h03
    } cmd_e;

    localparam byte_t REPLY_CLEAR_DONE = 8'hA5;
    localparam byte_t REPLY_BAD_CMD    = 8'hEE;  // Unknown opcode.

    // Debug unit states.
    typedef enum logic [2:0] {
        IDLE,
        LOAD_BYTES,
        WRITE_WORD,
        READ_ADDR,
        READ_MEM,
        SEND_BYTES,
        CLEAR_REQ,
        CLEAR_RELEASE
    } state_e;

endpackage

//--- baud_rate_generator.sv
`timescale 1ns/1ps

module baud_rate_generator (
    input  logic i_clock,
    input  logic i_rst_n,
    output logic o_tick
);

    import debug_pkg::*;

    logic [TICK_CNT_WIDTH-1:0] count_q;  // Cycles left until the next tick.

    // Down-counter, one tick per wrap.
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count_q <= TICK_CNT_WIDTH'(TICK_DIVISOR - 1);
            o_tick  <= 1'b0;
        end else if (count_q == '0) begin
            count_q <= TICK_CNT_WIDTH'(TICK_DIVISOR - 1);  // Reload.
            o_tick  <= 1'b1;
        end else begin
            count_q <= count_q - 1'b1;
            o_tick  <= 1'b0;
        end
    end

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic             i_clock,
    input  logic             i_rst_n,
    input  logic             i_tick,
    input  logic             i_bit_rx,
    output logic             o_rx_done,
    output debug_pkg::byte_t o_data
);

    import debug_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e                   state_q;
    logic [2:0]                  sync_q;      // Two sync flops, then edge history.
    logic [SAMPLE_CNT_WIDTH-1:0] tick_cnt_q;  // Ticks since last sample point.
    logic [BIT_CNT_WIDTH-1:0]    bit_cnt_q;
    byte_t                       shift_q;     // LSB arrives first.
    logic                        rx_bit;
    logic                        rx_fall;
    logic                        sample;

    assign rx_bit  = sync_q[1];
    assign rx_fall = sync_q[2] & ~sync_q[1];  // Start of a frame.
    assign sample  = i_tick && (tick_cnt_q == SAMPLE_CNT_WIDTH'(OVERSAMPLE - 1));
    assign o_data  = shift_q;

    // Line idles high.
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[1:0], i_bit_rx};
        end
    end

    ////////////////////////////////////////
    // Frame FSM.
    ////////////////////////////////////////

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= RX_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            o_rx_done  <= 1'b0;
        end else begin
            o_rx_done <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    tick_cnt_q <= '0;
                    if (rx_fall) state_q <= RX_START;
                end
                RX_START: begin
                    if (i_tick && tick_cnt_q == SAMPLE_CNT_WIDTH'(OVERSAMPLE / 2 - 1)) begin
                        tick_cnt_q <= '0;                         // Realign on mid-bit.
                        bit_cnt_q  <= '0;
                        state_q    <= rx_bit ? RX_IDLE : RX_DATA; // Glitch, not a start.
                    end else if (i_tick) begin
                        tick_cnt_q <= tick_cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (i_tick) tick_cnt_q <= tick_cnt_q + 1'b1;  // Wraps every bit.
                    if (sample) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == BIT_CNT_WIDTH'(BYTE_WIDTH - 1)) state_q <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (i_tick) tick_cnt_q <= tick_cnt_q + 1'b1;
                    if (sample) begin
                        o_rx_done <= rx_bit;     // Bad stop bit drops the byte.
                        state_q   <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Data shift register.
    always_ff @(posedge i_clock) begin
        if (state_q == RX_DATA && sample) begin
            shift_q <= {rx_bit, shift_q[BYTE_WIDTH-1:1]};
        end
    end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic             i_clock,
    input  logic             i_rst_n,
    input  logic             i_tick,
    input  logic             i_tx_start,
    input  debug_pkg::byte_t i_data,
    output logic             o_bit_tx,
    output logic             o_tx_done
);

    import debug_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e                   state_q;
    logic [SAMPLE_CNT_WIDTH-1:0] tick_cnt_q;
    logic [BIT_CNT_WIDTH-1:0]    bit_cnt_q;
    logic [STOP_CNT_WIDTH-1:0]   stop_cnt_q;
    byte_t                       shift_q;
    logic                        bit_end;     // Last tick of the current bit.

    assign bit_end = i_tick && (tick_cnt_q == SAMPLE_CNT_WIDTH'(OVERSAMPLE - 1));

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= TX_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            stop_cnt_q <= '0;
            o_bit_tx   <= 1'b1;                    // Idle high.
            o_tx_done  <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (state_q == TX_IDLE) tick_cnt_q <= '0;
            else if (i_tick)        tick_cnt_q <= tick_cnt_q + 1'b1;
            case (state_q)
                TX_IDLE: if (i_tx_start) begin
                    o_bit_tx   <= 1'b0;            // Start bit.
                    bit_cnt_q  <= '0;
                    stop_cnt_q <= '0;
                    state_q    <= TX_START;
                end
                TX_START: if (bit_end) begin
                    o_bit_tx <= shift_q[0];
                    state_q  <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == BIT_CNT_WIDTH'(BYTE_WIDTH - 1)) begin
                        o_bit_tx <= 1'b1;
                        state_q  <= TX_STOP;
                    end else begin
                        o_bit_tx <= shift_q[1];    // Next bit, before the shift.
                    end
                end
                TX_STOP: if (bit_end) begin
                    stop_cnt_q <= stop_cnt_q + 1'b1;
                    if (stop_cnt_q == STOP_CNT_WIDTH'(STOP_BITS - 1)) begin
                        o_tx_done <= 1'b1;
                        state_q   <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Byte latch and shift.
    always_ff @(posedge i_clock) begin
        if (state_q == TX_IDLE && i_tx_start) shift_q <= i_data;
        else if (state_q == TX_DATA && bit_end) shift_q <= shift_q >> 1;
    end

    // The debug unit only starts a byte once the previous frame is done.
    assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_tx_start |-> state_q == TX_IDLE);

endmodule

//--- program_memory.sv
`timescale 1ns/1ps

module program_memory (
    input  logic             i_clock,
    input  logic             i_rst_n,
    input  logic             i_write_en,
    input  logic             i_read_en,
    input  logic             i_soft_reset_req,
    input  debug_pkg::addr_t i_addr,
    input  debug_pkg::word_t i_data,
    output debug_pkg::word_t o_data,
    output logic             o_soft_reset_ack
);

    import debug_pkg::*;

    word_t               mem_q [MEM_DEPTH];   // Instruction RAM.
    logic [ADDR_WIDTH:0] clear_cnt_q;         // MSB set once the sweep is over.
    logic                clearing;

    assign clearing = i_soft_reset_req && !o_soft_reset_ack && !clear_cnt_q[ADDR_WIDTH];

    ////////////////////////////////////////
    // Single port, registered read.
    ////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (clearing) begin
            mem_q[clear_cnt_q[ADDR_WIDTH-1:0]] <= '0;  // One word per cycle.
        end else if (i_write_en) begin
            mem_q[i_addr] <= i_data;
        end
        if (i_read_en) o_data <= mem_q[i_addr];        // Data next cycle.
    end

    // Soft reset handshake.
    // Ack rises one cycle after the last word, MEM_DEPTH + 1 after req.
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clear_cnt_q      <= '0;
            o_soft_reset_ack <= 1'b0;
        end else if (!i_soft_reset_req) begin
            clear_cnt_q      <= '0;
            o_soft_reset_ack <= 1'b0;                   // Req dropped, release.
        end else if (!o_soft_reset_ack) begin
            if (clear_cnt_q[ADDR_WIDTH]) begin
                clear_cnt_q      <= '0;
                o_soft_reset_ack <= 1'b1;
            end else begin
                clear_cnt_q <= clear_cnt_q + 1'b1;
            end
        end
    end

    // Ack only ever answers a request seen on the previous edge.
    assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_soft_reset_ack |-> $past(i_soft_reset_req));

endmodule

//--- debug_unit.sv
`timescale 1ns/1ps

module debug_unit (
    input  logic             i_clock,
    input  logic             i_rst_n,
    input  logic             i_rx_done,
    input  debug_pkg::byte_t i_rx_data,
    input  logic             i_tx_done,
    output logic             o_tx_start,
    output debug_pkg::byte_t o_tx_data,
    output debug_pkg::addr_t o_mem_addr,
    output debug_pkg::word_t o_mem_wdata,
    input  debug_pkg::word_t i_mem_rdata,
    output logic             o_mem_write_en,
    output logic             o_mem_read_en,
    output logic             o_soft_reset_req,
    input  logic             i_soft_reset_ack,
    output logic             o_program_loaded
);

    import debug_pkg::*;

    state_e     state_q;
    logic [1:0] byte_cnt_q;    // Bytes taken of the current word or address.
    word_t      word_q;        // Instruction being assembled.
    addr_t      addr_q;        // Write pointer or read address.
    word_t      reply_q;       // Reply bytes, top byte goes out first.
    logic [2:0] send_left_q;   // Reply bytes still to send.
    logic       tx_wait_q;     // Byte started, waiting on done.
    logic       rd_wait_q;     // Read issued, data due this cycle.
    logic       last_word;

    // Single byte reply, left aligned.
    function automatic word_t one_byte(byte_t b);
        return {b, {(WORD_WIDTH - BYTE_WIDTH){1'b0}}};
    endfunction

    assign o_mem_addr       = addr_q;
    assign o_mem_wdata      = word_q;
    assign o_mem_write_en   = (state_q == WRITE_WORD);
    assign o_mem_read_en    = (state_q == READ_MEM) && !rd_wait_q;
    assign o_soft_reset_req = (state_q == CLEAR_REQ);          // Held until ack.
    assign o_tx_data        = reply_q[WORD_WIDTH-1 -: BYTE_WIDTH];
    assign last_word        = (word_q[WORD_WIDTH-1 -: OPCODE_WIDTH] == HALT_OPCODE)
                           || (addr_q == addr_t'(MEM_DEPTH - 1)); // HALT or full.

    ////////////////////////////////////////
    // Command FSM.
    ////////////////////////////////////////

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q          <= IDLE;
            byte_cnt_q       <= '0;
            word_q           <= '0;
            addr_q           <= '0;
            reply_q          <= '0;
            send_left_q      <= '0;
            tx_wait_q        <= 1'b0;
            rd_wait_q        <= 1'b0;
            o_tx_start       <= 1'b0;
            o_program_loaded <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;                                // One-cycle pulse.
            case (state_q)
                IDLE: if (i_rx_done) begin
                    byte_cnt_q <= '0;
                    addr_q     <= '0;                          // Loads start at 0.
                    case (cmd_e'(i_rx_data))
                        CMD_LOAD:  state_q <= LOAD_BYTES;
                        CMD_READ:  state_q <= READ_ADDR;
                        CMD_CLEAR: state_q <= CLEAR_REQ;
                        default: begin
                            reply_q     <= one_byte(REPLY_BAD_CMD);
                            send_left_q <= 3'd1;
                            state_q     <= SEND_BYTES;
                        end
                    endcase
                end
                LOAD_BYTES: if (i_rx_done) begin
                    word_q     <= {word_q[WORD_WIDTH-BYTE_WIDTH-1:0], i_rx_data}; // MSB first.
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    if (byte_cnt_q == 2'(BYTES_PER_WORD - 1)) state_q <= WRITE_WORD;
                end
                WRITE_WORD: begin                              // Write strobe this cycle.
                    if (last_word) begin
                        reply_q          <= one_byte(addr_q[BYTE_WIDTH-1:0] + 1'b1);
                        send_left_q      <= 3'd1;
                        o_program_loaded <= 1'b1;
                        state_q          <= SEND_BYTES;
                    end else begin
                        addr_q  <= addr_q + 1'b1;
                        state_q <= LOAD_BYTES;
                    end
                end
                READ_ADDR: if (i_rx_done) begin
                    addr_q     <= addr_t'({addr_q, i_rx_data}); // High byte top bits drop.
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    if (byte_cnt_q == 2'd1) state_q <= READ_MEM;
                end
                READ_MEM: begin
                    rd_wait_q <= !rd_wait_q;
                    if (rd_wait_q) begin
                        reply_q     <= i_mem_rdata;
                        send_left_q <= 3'(BYTES_PER_WORD);
                        state_q     <= SEND_BYTES;
                    end
                end
                SEND_BYTES: begin
                    if (!tx_wait_q) begin
                        o_tx_start <= 1'b1;
                        tx_wait_q  <= 1'b1;
                    end else if (i_tx_done) begin
                        tx_wait_q   <= 1'b0;
                        reply_q     <= reply_q << BYTE_WIDTH;  // Next byte to the top.
                        send_left_q <= send_left_q - 1'b1;
                        if (send_left_q == 3'd1) state_q <= IDLE;
                    end
                end
                CLEAR_REQ: if (i_soft_reset_ack) state_q <= CLEAR_RELEASE;
                CLEAR_RELEASE: if (!i_soft_reset_ack) begin    // Four-phase done.
                    o_program_loaded <= 1'b0;
                    reply_q          <= one_byte(REPLY_CLEAR_DONE);
                    send_left_q      <= 3'd1;
                    state_q          <= SEND_BYTES;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request stays up until the memory has acknowledged the clear.
    assert property (@(posedge i_clock) disable iff (!i_rst_n)
        $fell(o_soft_reset_req) |-> $past(i_soft_reset_ack));

endmodule

//--- debug_top.sv
`timescale 1ns/1ps

module debug_top (
    input  logic i_clock,
    input  logic i_rst_n,
    input  logic i_uart_rx,
    output logic o_uart_tx,
    output logic o_program_loaded
);

    import debug_pkg::*;

    ////////////////////////////////////////
    // Internal links.
    ////////////////////////////////////////

    logic  tick;             // 16x baud.
    logic  rx_done;
    byte_t rx_data;
    logic  tx_start;
    logic  tx_done;
    byte_t tx_data;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_write_en;
    logic  mem_read_en;
    logic  soft_reset_req;
    logic  soft_reset_ack;

    baud_rate_generator u_baud_rate_generator (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .o_tick  (tick)
    );

    // Host to debug unit.
    uart_rx u_uart_rx (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_tick    (tick),
        .i_bit_rx  (i_uart_rx),
        .o_rx_done (rx_done),
        .o_data    (rx_data)
    );

    // Debug unit to host.
    uart_tx u_uart_tx (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_tick     (tick),
        .i_tx_start (tx_start),
        .i_data     (tx_data),
        .o_bit_tx   (o_uart_tx),
        .o_tx_done  (tx_done)
    );

    program_memory u_program_memory (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_write_en       (mem_write_en),
        .i_read_en        (mem_read_en),
        .i_soft_reset_req (soft_reset_req),
        .i_addr           (mem_addr),
        .i_data           (mem_wdata),
        .o_data           (mem_rdata),
        .o_soft_reset_ack (soft_reset_ack)
    );

    debug_unit u_debug_unit (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_rx_done        (rx_done),
        .i_rx_data        (rx_data),
        .i_tx_done        (tx_done),
        .o_tx_start       (tx_start),
        .o_tx_data        (tx_data),
        .o_mem_addr       (mem_addr),
        .o_mem_wdata      (mem_wdata),
        .i_mem_rdata      (mem_rdata),
        .o_mem_write_en   (mem_write_en),
        .o_mem_read_en    (mem_read_en),
        .o_soft_reset_req (soft_reset_req),
        .i_soft_reset_ack (soft_reset_ack),
        .o_program_loaded (o_program_loaded)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clock,
    output logic o_rst_n
);

    localparam int HALF_PERIOD_NS = 50;   // 100 ns clock.
    localparam int RESET_CYCLES   = 10;

    initial begin
        o_clock = 1'b0;
        forever #(HALF_PERIOD_NS) o_clock = ~o_clock;
    end

    // Reset low for the first cycles, released just off the edge.
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clock);
        #1 o_rst_n = 1'b1;
    end

endmodule

//--- tb_debug_top.sv
`timescale 1ns/1ps

module tb_debug_top;

    import debug_pkg::*;

    typedef byte_t byte_q_t[$];
    typedef word_t word_q_t[$];

    localparam int BIT_CYCLES    = OVERSAMPLE * TICK_DIVISOR;  // 80 clocks per bit.
    localparam int HALF_BIT      = BIT_CYCLES / 2;
    localparam int FRAME_BITS    = 1 + BYTE_WIDTH + STOP_BITS;
    localparam int START_TIMEOUT = 60000;                      // Longest load plus margin.
    localparam int RESET_TIMEOUT = 100;
    localparam int DRIVE_DELAY   = 1;                          // ns after the rising edge.

    logic    clock;
    logic    rst_n;
    logic    uart_rx;
    logic    uart_tx;
    logic    program_loaded;

    word_t   ref_mem [MEM_DEPTH];  // Reference copy of the program memory.
    logic    ref_loaded;           // Expected load-done flag.
    byte_q_t exp_q;                // Reply bytes still owed by the DUT.
    byte_q_t rx_q;                 // Reply bytes seen on the line.
    int      value_errors;
    int      other_errors;
    integer  seed;
    byte_t   cmp_expected;
    byte_t   cmp_actual;

    tb_clock_gen clock_gen_i (
        .o_clock (clock),
        .o_rst_n (rst_n)
    );

    debug_top debug_top_i (
        .i_clock          (clock),
        .i_rst_n          (rst_n),
        .i_uart_rx        (uart_rx),
        .o_uart_tx        (uart_tx),
        .o_program_loaded (program_loaded)
    );

    ////////////////////////////////////////
    // Result checks.
    ////////////////////////////////////////

    task automatic check_byte(input byte_t expected, input byte_t actual, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected 0x%02h, got 0x%02h",
                     $time, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_word(input word_t expected, input word_t actual, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s.", $time, what);
        other_errors++;
        finish_run();
    endtask

    ////////////////////////////////////////
    // Reference model.
    ////////////////////////////////////////

    // Expected reply for one command. Keeps ref_mem in step with the DUT.
    function automatic byte_q_t ref_reply(input byte_t cmd, input byte_q_t args);
        byte_q_t reply;
        word_t   w;
        addr_t   a;
        int      count;
        int      k;
        logic    done;
        count = 0;
        case (cmd)
            CMD_LOAD: begin
                k    = 0;
                a    = '0;
                done = 1'b0;
                while (!done && k + BYTES_PER_WORD <= args.size()) begin
                    w = {args[k], args[k+1], args[k+2], args[k+3]};  // MSB first.
                    ref_mem[a] = w;
                    count++;
                    k += BYTES_PER_WORD;
                    done = (w[WORD_WIDTH-1 -: OPCODE_WIDTH] == HALT_OPCODE)
                        || (count == MEM_DEPTH);                     // HALT or full.
                    a = a + 1'b1;
                end
                ref_loaded = 1'b1;
                reply.push_back(byte_t'(count));                     // Low byte only.
            end
            CMD_READ: begin
                a = addr_t'({args[0], args[1]});                     // Top bits ignored.
                w = ref_mem[a];
                repeat (BYTES_PER_WORD) begin
                    reply.push_back(w[WORD_WIDTH-1 -: BYTE_WIDTH]);
                    w = w << BYTE_WIDTH;
                end
            end
            CMD_CLEAR: begin
                foreach (ref_mem[j]) ref_mem[j] = '0;
                ref_loaded = 1'b0;
                reply.push_back(REPLY_CLEAR_DONE);
            end
            default: reply.push_back(REPLY_BAD_CMD);
        endcase
        return reply;
    endfunction

    function automatic word_t random_word(input logic halt);
        word_t w;
        w = $random(seed);
        if (halt) w[WORD_WIDTH-1 -: OPCODE_WIDTH] = HALT_OPCODE;
        else w[WORD_WIDTH-OPCODE_WIDTH] = 1'b1;                      // Opcode never zero.
        return w;
    endfunction

    ////////////////////////////////////////
    // UART host model.
    ////////////////////////////////////////

    task automatic send_byte(input byte_t b);
        logic [FRAME_BITS-1:0] frame;
        frame = {{STOP_BITS{1'b1}}, b, 1'b0};  // Start bit goes out first.
        repeat (FRAME_BITS) begin
            @(posedge clock);
            #(DRIVE_DELAY);
            uart_rx = frame[0];
            frame   = frame >> 1;
            repeat (BIT_CYCLES - 1) @(posedge clock);
        end
    endtask

    // Samples on the falling clock edge at mid-bit.
    task automatic receive_byte(output byte_t b);
        int waited;
        waited = 0;
        b      = '0;
        while (uart_tx !== 1'b0 && waited < START_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (waited >= START_TIMEOUT) begin
            report_timeout("no start bit on o_uart_tx");
        end else begin
            repeat (HALF_BIT) @(negedge clock);
            if (uart_tx !== 1'b0) begin
                $display("Start bit on o_uart_tx did not hold at %0t ns.", $time);
                other_errors++;
            end
            repeat (BYTE_WIDTH) begin
                repeat (BIT_CYCLES) @(negedge clock);
                b = {uart_tx, b[BYTE_WIDTH-1:1]};          // LSB arrives first.
            end
            repeat (STOP_BITS) begin
                repeat (BIT_CYCLES) @(negedge clock);
                if (uart_tx !== 1'b1) begin
                    $display("Stop bit on o_uart_tx was low at %0t ns.", $time);
                    other_errors++;
                end
            end
        end
    endtask

    task automatic run_command(input byte_t cmd, input byte_q_t args, output byte_q_t reply);
        byte_q_t expected;
        byte_q_t frame_bytes;
        byte_q_t got;
        byte_t   b;
        logic    idle_ok;
        expected    = ref_reply(cmd, args);
        frame_bytes = args;
        frame_bytes.push_front(cmd);
        foreach (expected[i]) exp_q.push_back(expected[i]);
        fork
            begin
                foreach (frame_bytes[i]) send_byte(frame_bytes[i]);
            end
            begin
                repeat (expected.size()) begin
                    receive_byte(b);
                    got.push_back(b);
                    rx_q.push_back(b);
                end
            end
        join
        reply   = got;
        idle_ok = 1'b1;
        repeat (2 * BIT_CYCLES) begin                      // Tail of the reply.
            @(negedge clock);
            if (uart_tx !== 1'b1) idle_ok = 1'b0;
        end
        if (!idle_ok) begin
            $display("Extra activity on o_uart_tx after the reply at %0t ns.", $time);
            other_errors++;
        end
    endtask

    task automatic load_words(input word_q_t words);
        byte_q_t args;
        byte_q_t reply;
        word_t   w;
        foreach (words[i]) begin
            w = words[i];
            repeat (BYTES_PER_WORD) begin
                args.push_back(w[WORD_WIDTH-1 -: BYTE_WIDTH]);
                w = w << BYTE_WIDTH;
            end
        end
        run_command(CMD_LOAD, args, reply);
        check_flag(ref_loaded, program_loaded, "o_program_loaded after load");
    endtask

    // High byte carries junk in its unused top bits when fill is set.
    task automatic read_and_check(input addr_t addr, input byte_t fill);
        byte_q_t args;
        byte_q_t reply;
        word_t   expected;
        word_t   got;
        expected = ref_mem[addr];
        args.push_back((fill & 8'hF8) | byte_t'(addr >> BYTE_WIDTH));
        args.push_back(addr[BYTE_WIDTH-1:0]);
        run_command(CMD_READ, args, reply);
        got = '0;
        foreach (reply[i]) got = {got[WORD_WIDTH-BYTE_WIDTH-1:0], reply[i]};
        check_word(expected, got, $sformatf("word at address %0d", addr));
    endtask

    // Reply byte comparison.
    initial begin : compare_process
        forever begin
            @(posedge clock);
            if (rx_q.size() > 0) begin
                cmp_actual = rx_q.pop_front();
                if (exp_q.size() == 0) begin
                    $display("Reply byte 0x%02h arrived unasked at %0t ns.", cmp_actual, $time);
                    other_errors++;
                end else begin
                    cmp_expected = exp_q.pop_front();
                    check_byte(cmp_expected, cmp_actual, "reply byte");
                end
            end
        end
    end

    ////////////////////////////////////////
    // Scenarios.
    ////////////////////////////////////////

    initial begin : scenarios
        word_q_t words;
        byte_q_t args;
        byte_q_t reply;
        int      waited;
        int      i;
        byte_t   bad_cmds [3];
        uart_rx      = 1'b1;                           // Line idles high.
        value_errors = 0;
        other_errors = 0;
        seed         = 13;
        ref_loaded   = 1'b0;
        bad_cmds     = '{8'h00, 8'h07, 8'hFF};
        foreach (ref_mem[a]) ref_mem[a] = '0;
        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            report_timeout("reset never released");
        end else begin
            repeat (4) @(negedge clock);
            check_flag(1'b1, uart_tx, "o_uart_tx after reset");
            check_flag(1'b0, program_loaded, "o_program_loaded after reset");

            run_command(CMD_CLEAR, args, reply);       // Known memory contents.

            // Eight words and a HALT.
            for (i = 0; i < 8; i++) words.push_back(random_word(1'b0));
            words.push_back(random_word(1'b1));
            load_words(words);
            for (i = 0; i <= 9; i++) read_and_check(addr_t'(i), 8'h00);

            run_command(CMD_CLEAR, args, reply);
            check_flag(1'b0, program_loaded, "o_program_loaded after clear");
            read_and_check(addr_t'(0), 8'h00);
            read_and_check(addr_t'(4), 8'h00);
            read_and_check(addr_t'(8), 8'h00);
            read_and_check(addr_t'(1500), 8'hF8);
            read_and_check(addr_t'(MEM_DEPTH - 1), 8'hF8);

            // Second, shorter load.
            words.delete();
            words.push_back(random_word(1'b0));
            words.push_back(random_word(1'b0));
            words.push_back(random_word(1'b1));
            load_words(words);
            for (i = 0; i <= 3; i++) read_and_check(addr_t'(i), 8'hF8);

            // Unknown opcodes leave the loaded words in place.
            foreach (bad_cmds[k]) begin
                run_command(bad_cmds[k], args, reply);
                read_and_check(addr_t'(k), 8'h00);
            end
            check_flag(ref_loaded, program_loaded, "o_program_loaded after bad commands");

            repeat (4) @(posedge clock);
            if (exp_q.size() != 0 || rx_q.size() != 0) begin
                $display("Reply bytes left over at the end: %0d owed, %0d unchecked.",
                         exp_q.size(), rx_q.size());
                other_errors++;
            end
            finish_run();
        end
    end

endmodule

//--- project.f
debug_pkg.sv
baud_rate_generator.sv
uart_rx.sv
uart_tx.sv
program_memory.sv
debug_unit.sv
debug_top.sv
tb_clock_gen.sv
tb_debug_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_debug_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
SIM       ?= $(BUILD_DIR)/V$(TOP)
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Testbench passed
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
